//--- vred_pkg.sv
package vred_pkg;

    // Vector engine sizes
    localparam int LANES        = 8;
    localparam int LEVELS       = $clog2(LANES);
    localparam int NUM_ELEMENTS = 8;
    localparam int IDX_W        = $clog2(NUM_ELEMENTS);
    // Alignment depth for payloads that travel beside the compare tree
    localparam int PIPE_STAGES  = LEVELS;

    typedef struct packed {
        logic       sign;
        logic [4:0] exponent;
        logic [9:0] mantissa;
    } fp16_t;

    typedef fp16_t [NUM_ELEMENTS-1:0] vec_t;

    typedef enum logic {
        RED_MAX = 1'b0,
        RED_MIN = 1'b1
    } red_op_e;

    typedef struct packed {
        red_op_e          op;
        logic [IDX_W-1:0] imm;
        logic             broadcast;
        logic             clear;
    } red_ctrl_t;

    typedef struct packed {
        logic      valid;
        vec_t      lanes;
        vec_t      dest;
        red_ctrl_t ctrl;
    } red_req_t;

    typedef struct packed {
        logic valid;
        vec_t result;
    } red_rsp_t;

    // Sign-magnitude order, so -0 sits just below +0
    function automatic logic fp16_less(fp16_t a, fp16_t b);
        logic [14:0] mag_a;
        logic [14:0] mag_b;
        mag_a = {a.exponent, a.mantissa};
        mag_b = {b.exponent, b.mantissa};
        if (a.sign != b.sign) begin
            return a.sign;
        end
        // Negative values order by reversed magnitude
        if (a.sign) begin
            return mag_a > mag_b;
        end
        return mag_a < mag_b;
    endfunction

    function automatic fp16_t fp16_pick(fp16_t a, fp16_t b, red_op_e op);
        if (op == RED_MAX) begin
            return fp16_less(a, b) ? b : a;
        end
        return fp16_less(a, b) ? a : b;
    endfunction

endpackage

//--- vred_delay_line.sv
`timescale 1ns/1ns

module vred_delay_line #(
    parameter type payload_t = logic,
    parameter int  STAGES    = 1
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     valid,
    input  payload_t data_in,
    output payload_t data_out
);

    payload_t          stage_q [STAGES];
    payload_t          stage_d [STAGES];
    logic [STAGES-1:0] vld_q;
    // Load enable per stage, plus the valid leaving the last stage on top
    logic [STAGES:0]   en;

    assign en = {vld_q, valid};

    always_comb begin
        stage_d[0] = data_in;
        for (int s = 1; s < STAGES; s++) begin
            stage_d[s] = stage_q[s-1];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            vld_q <= '0;
            for (int s = 0; s < STAGES; s++) begin
                stage_q[s] <= '0;
            end
        end else begin
            vld_q <= en[STAGES-1:0];
            // Idle stages hold, so separate requests can share the chain
            for (int s = 0; s < STAGES; s++) begin
                if (en[s]) begin
                    stage_q[s] <= stage_d[s];
                end
            end
        end
    end

    assign data_out = stage_q[STAGES-1];

    // A payload reaching the end was loaded from a known input
    a_out_known: assert property (@(posedge CLK) disable iff (!nRST)
        en[STAGES] |-> !$isunknown(data_out));

endmodule

//--- vred_tree.sv
`timescale 1ns/1ns

module vred_tree import vred_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  logic    valid_in,
    input  red_op_e op,
    input  vec_t    lanes_in,
    output fp16_t   data_out,
    output logic    valid_out
);

    // Level l keeps LANES >> (l+1) live entries in its low slots
    vec_t              lvl_q   [LEVELS];
    vec_t              lvl_in  [LEVELS];
    red_op_e           op_q    [LEVELS];
    red_op_e           op_in   [LEVELS];
    logic [LEVELS-1:0] vld_q;
    logic [LEVELS-1:0] vld_in;

    // Pairwise compare of neighbours, result packed into the low half
    function automatic vec_t pick_pairs(vec_t v, red_op_e sel);
        vec_t r;
        r = '0;
        for (int i = 0; i < LANES/2; i++) begin
            r[i] = fp16_pick(v[2*i], v[2*i+1], sel);
        end
        return r;
    endfunction

    always_comb begin
        lvl_in[0] = lanes_in;
        op_in[0]  = op;
        vld_in[0] = valid_in;
        for (int l = 1; l < LEVELS; l++) begin
            lvl_in[l] = lvl_q[l-1];
            op_in[l]  = op_q[l-1];
            vld_in[l] = vld_q[l-1];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            vld_q <= '0;
            for (int l = 0; l < LEVELS; l++) begin
                lvl_q[l] <= '0;
                op_q[l]  <= RED_MAX;
            end
        end else begin
            vld_q <= vld_in;
            for (int l = 0; l < LEVELS; l++) begin
                // Op rides with its data so mixed MAX/MIN requests stay apart
                if (vld_in[l]) begin
                    lvl_q[l] <= pick_pairs(lvl_in[l], op_in[l]);
                    op_q[l]  <= op_in[l];
                end
            end
        end
    end

    assign data_out  = lvl_q[LEVELS-1][0];
    assign valid_out = vld_q[LEVELS-1];

    a_valid_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown(valid_out));

endmodule

//--- vreduction.sv
`timescale 1ns/1ns

module vreduction import vred_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  red_req_t req,
    output red_rsp_t rsp
);

    red_req_t  req_q;
    fp16_t     tree_val;
    logic      tree_vld;
    vec_t      dest_al;
    red_ctrl_t ctrl_al;
    vec_t      merged;
    red_rsp_t  rsp_q;

    // Input register
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            req_q <= '0;
        end else begin
            req_q.valid <= req.valid;
            if (req.valid) begin
                req_q.lanes <= req.lanes;
                req_q.dest  <= req.dest;
                req_q.ctrl  <= req.ctrl;
            end
        end
    end

    vred_tree tree_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .valid_in  (req_q.valid),
        .op        (req_q.ctrl.op),
        .lanes_in  (req_q.lanes),
        .data_out  (tree_val),
        .valid_out (tree_vld)
    );

    // Destination vector and controls follow the tree level by level
    vred_delay_line #(
        .payload_t (vec_t),
        .STAGES    (PIPE_STAGES)
    ) dest_dly_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .valid    (req_q.valid),
        .data_in  (req_q.dest),
        .data_out (dest_al)
    );

    vred_delay_line #(
        .payload_t (red_ctrl_t),
        .STAGES    (PIPE_STAGES)
    ) ctrl_dly_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .valid    (req_q.valid),
        .data_in  (req_q.ctrl),
        .data_out (ctrl_al)
    );

    // Write-back merge, broadcast first
    always_comb begin
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            if (ctrl_al.broadcast || i == int'(ctrl_al.imm)) begin
                merged[i] = tree_val;
            end else if (ctrl_al.clear) begin
                merged[i] = '0;
            end else begin
                merged[i] = dest_al[i];
            end
        end
    end

    // Output register, result holds between pulses
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rsp_q <= '0;
        end else begin
            rsp_q.valid <= tree_vld;
            if (tree_vld) begin
                rsp_q.result <= merged;
            end
        end
    end

    assign rsp = rsp_q;

    a_no_bcast_clear: assert property (@(posedge CLK) disable iff (!nRST)
        req.valid |-> !(req.ctrl.broadcast && req.ctrl.clear));

endmodule

//--- vred_top.sv
`timescale 1ns/1ns

module vred_top import vred_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  red_req_t req,
    output red_rsp_t rsp
);

    // Single reduction unit, requests go straight in
    vreduction vred_i (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (req),
        .rsp  (rsp)
    );

endmodule

//--- tb_vred.sv
`timescale 1ns/1ns

module tb_vred import vred_pkg::*; ();

    // Rising edges from the request sample to the one that sees rsp.valid high
    localparam int LATENCY = 5;

    logic     CLK;
    logic     nRST;
    red_req_t req;
    red_rsp_t rsp;

    int   seed      = 69396;
    int   cyc       = 0;
    int   errors    = 0;
    int   requests  = 0;
    int   responses = 0;
    int   tests     = 0;
    vec_t exp_q [$];
    int   due_q [$];

    vred_top dut_i (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (req),
        .rsp  (rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    task automatic check_result(input string name, input vec_t got, input vec_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Monotonic key for sign-magnitude order, -0 just below +0
    function automatic int order_key(fp16_t v);
        int mag;
        mag = {17'd0, v.exponent, v.mantissa};
        if (v.sign) begin
            return 32767 - mag;
        end
        return 32768 + mag;
    endfunction

    function automatic fp16_t reduce_lanes(vec_t lanes, red_op_e op);
        fp16_t best;
        best = lanes[0];
        for (int i = 1; i < LANES; i++) begin
            if (op == RED_MAX && order_key(lanes[i]) > order_key(best)) begin
                best = lanes[i];
            end else if (op == RED_MIN && order_key(lanes[i]) < order_key(best)) begin
                best = lanes[i];
            end
        end
        return best;
    endfunction

    function automatic vec_t expected_result(vec_t lanes, vec_t dest, red_ctrl_t ctrl);
        vec_t  res;
        fp16_t red;
        red = reduce_lanes(lanes, ctrl.op);
        if (ctrl.broadcast) begin
            for (int i = 0; i < NUM_ELEMENTS; i++) begin
                res[i] = red;
            end
        end else begin
            // Clear zeros the other elements
            if (ctrl.clear) begin
                res = '0;
            end else begin
                res = dest;
            end
            res[ctrl.imm] = red;
        end
        return res;
    endfunction

    // Zeros of both signs show up often, the rest is raw bit patterns
    function automatic fp16_t random_fp16();
        logic [31:0] r;
        r = $random(seed);
        case (r[19:17])
            3'd0:    return fp16_t'(16'h0000);
            3'd1:    return fp16_t'(16'h8000);
            default: return fp16_t'(r[15:0]);
        endcase
    endfunction

    // Mode 0 merge, 1 broadcast, 2 clear, 3 any of them
    task automatic drive_request(input int mode);
        logic [31:0] r;
        int          m;
        r = $random(seed);
        m = (mode == 3) ? {30'd0, r[5:4]} % 3 : mode;
        req.valid = 1'b1;
        for (int i = 0; i < LANES; i++) begin
            req.lanes[i] = random_fp16();
            // Occasional duplicate lane gives equal operands
            if (i > 0 && r[8 + (i % 8)] && r[16]) begin
                req.lanes[i] = req.lanes[i-1];
            end
        end
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            req.dest[i] = random_fp16();
        end
        req.ctrl.op        = red_op_e'(r[0]);
        req.ctrl.imm       = r[3:1];
        req.ctrl.broadcast = (m == 1);
        req.ctrl.clear     = (m == 2);
        exp_q.push_back(expected_result(req.lanes, req.dest, req.ctrl));
        due_q.push_back(cyc + LATENCY);
        requests++;
    endtask

    task automatic wait_drain(input string name);
        for (int t = 0; t < 50 && exp_q.size() != 0; t++) begin
            @(negedge CLK);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout in %s: %0d responses never arrived", name, exp_q.size());
        end
    endtask

    task automatic run_requests(input string name, input int mode, input int count,
                                input int max_gap);
        int err0;
        int rsp0;
        int gap;
        err0 = errors;
        rsp0 = responses;
        for (int n = 0; n < count; n++) begin
            @(negedge CLK);
            drive_request(mode);
            gap = {24'd0, 8'($random(seed))};
            gap = gap % (max_gap + 1);
            for (int g = 0; g < gap; g++) begin
                @(negedge CLK);
                req.valid = 1'b0;
            end
        end
        @(negedge CLK);
        req.valid = 1'b0;
        wait_drain(name);
        if (responses - rsp0 != count) begin
            errors++;
            $display("%s: %0d requests but %0d responses", name, count, responses - rsp0);
        end
        tests++;
        $display("Test %s: %0d requests, %0d errors", name, count, errors - err0);
    endtask

    // Response checker, a pending head due now must show up exactly now
    always @(negedge CLK) begin
        if (nRST) begin
            if (due_q.size() != 0 && due_q[0] == cyc) begin
                check_valid("rsp.valid", rsp.valid, 1'b1);
                check_result("rsp.result", rsp.result, exp_q[0]);
                if (rsp.valid) begin
                    responses++;
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                check_valid("rsp.valid", rsp.valid, 1'b0);
            end
        end
    end

    initial begin
        int err0;
        req  = '0;
        nRST = 1'b0;
        err0 = 0;
        for (int c = 0; c < 16; c++) begin
            @(negedge CLK);
            check_valid("rsp.valid", rsp.valid, 1'b0);
        end
        nRST = 1'b1;
        // Idle after reset, the checker expects no pulses
        repeat (10) @(negedge CLK);
        tests++;
        $display("Test reset: %0d errors", errors - err0);

        run_requests("merge", 0, 40, 3);
        run_requests("broadcast", 1, 30, 3);
        run_requests("clear", 2, 30, 3);
        run_requests("back_to_back", 3, 80, 2);

        $display("Tests %0d, requests %0d, responses %0d, errors %0d",
                 tests, requests, responses, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- flist.f
vred_pkg.sv
vred_delay_line.sv
vred_tree.sv
vreduction.sv
vred_top.sv
tb_vred.sv

//--- Makefile
# Verilator build for the vector reduction unit

VERILATOR ?= verilator
TOP       ?= tb_vred
RTL_TOP   ?= vred_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
FAIL_MSG  ?= Verification failed

SOURCES := $(shell cat $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
